//--- design/mem_pkg.sv
package mem_pkg;

  typedef logic [31:0] addr_t;  // byte address.
  typedef logic [63:0] data_t;  // one data word.
  typedef logic [7:0]  strb_t;  // byte strobes or byte enables.
  typedef logic [2:0]  burst_t; // avalon burst count.

  // low address bits that pick a byte within a word.
  localparam int word_offset_bits = 3;

  localparam addr_t offset_mask = addr_t'((1 << word_offset_bits) - 1);
  localparam strb_t strb_all = '1;
  localparam burst_t burst_one = burst_t'(1); // single beat only.

endpackage

//--- design/req_fifo.sv
`timescale 1ns/1ns

module req_fifo import mem_pkg::*; #(
  parameter int fifo_depth = 4
) (
  input  logic  clock,
  input  logic  reset,
  input  logic  push,
  input  addr_t push_addr,
  input  data_t push_wdata,
  input  strb_t push_wstrb,
  input  logic  head_pop,
  output logic  full,
  output logic  head_valid,
  output addr_t head_addr,
  output data_t head_wdata,
  output strb_t head_wstrb
);

  localparam int ptr_bits = $clog2(fifo_depth);
  localparam int count_bits = $clog2(fifo_depth + 1);

  addr_t addr_mem [fifo_depth];
  data_t wdata_mem [fifo_depth];
  strb_t wstrb_mem [fifo_depth];

  logic [ptr_bits-1:0]   wr_ptr;
  logic [ptr_bits-1:0]   rd_ptr;
  logic [count_bits-1:0] count;
  logic                  do_pop;

  assign do_pop = head_pop && head_valid;
  assign full = (count == count_bits'(fifo_depth));
  assign head_valid = (count != '0);

  assign head_addr = addr_mem[rd_ptr];
  assign head_wdata = wdata_mem[rd_ptr];
  assign head_wstrb = wstrb_mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (!reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two.
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, do_pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count; // none, or push and pop together.
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      addr_mem[wr_ptr] <= push_addr;
      wdata_mem[wr_ptr] <= push_wdata;
      wstrb_mem[wr_ptr] <= push_wstrb;
    end
  end

endmodule

//--- design/avl_master.sv
`timescale 1ns/1ns

module avl_master import mem_pkg::*; (
  input  logic   clock,
  input  logic   reset,
  input  logic   head_valid,
  input  addr_t  head_addr,
  input  data_t  head_wdata,
  input  strb_t  head_wstrb,
  output logic   head_pop,
  output logic   rsp_valid,
  output data_t  rsp_rdata,
  output addr_t  m_avl_address,
  output strb_t  m_avl_byteenable,
  output logic   m_avl_read,
  output logic   m_avl_write,
  output data_t  m_avl_writedata,
  output burst_t m_avl_burstcount,
  output logic   m_avl_lock,
  input  data_t  m_avl_readdata,
  input  logic   m_avl_waitrequest,
  input  logic   m_avl_readdatavalid
);

  typedef enum logic [1:0] {
    idle,
    load,
    store
  } state_t;

  state_t state;
  state_t state_next;
  logic   read_next;
  logic   write_next;
  logic   rsp_next;
  data_t  rdata_next;
  logic   is_load;
  logic   accepted;

  // the head entry is taken only from idle.
  assign head_pop = (state == idle) && head_valid;
  assign is_load = (head_wstrb == '0);
  assign accepted = (m_avl_read || m_avl_write) && !m_avl_waitrequest;

  always_comb begin
    state_next = state;
    read_next = m_avl_read && !accepted;  // drop after acceptance.
    write_next = m_avl_write && !accepted;
    rsp_next = 1'b0;
    rdata_next = '0;
    case (state)
      idle: begin
        if (head_valid) begin
          if (is_load) begin
            state_next = load;
            read_next = 1'b1;
          end else begin
            state_next = store;
            write_next = 1'b1;
          end
        end
      end
      load: begin
        if (m_avl_readdatavalid) begin
          state_next = idle;
          rsp_next = 1'b1;
          rdata_next = m_avl_readdata;
        end
      end
      store: begin
        if (accepted) begin
          state_next = idle;
          rsp_next = 1'b1; // stores answer with zero data.
        end
      end
      default: begin
        state_next = idle;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= idle;
      m_avl_read <= 1'b0;
      m_avl_write <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      state <= state_next;
      m_avl_read <= read_next;
      m_avl_write <= write_next;
      rsp_valid <= rsp_next;
    end
  end

  // command payload loads on pop and holds through waitrequest.
  always_ff @(posedge clock) begin
    if (head_pop) begin
      m_avl_address <= head_addr & ~offset_mask;
      m_avl_byteenable <= is_load ? strb_all : head_wstrb;
      m_avl_writedata <= head_wdata;
    end
    rsp_rdata <= rdata_next;
  end

  assign m_avl_burstcount = burst_one;
  assign m_avl_lock = 1'b0;

endmodule

//--- design/avl_ram.sv
`timescale 1ns/1ns

module avl_ram import mem_pkg::*; #(
  parameter int wait_cycles = 2,
  parameter int mem_words = 256
) (
  input  logic   clock,
  input  logic   reset,
  input  addr_t  m_avl_address,
  input  strb_t  m_avl_byteenable,
  input  logic   m_avl_read,
  input  logic   m_avl_write,
  input  data_t  m_avl_writedata,
  input  burst_t m_avl_burstcount, // single beat assumed.
  input  logic   m_avl_lock,       // no locking here.
  output data_t  m_avl_readdata,
  output logic   m_avl_waitrequest,
  output logic   m_avl_readdatavalid
);

  localparam int index_bits = (mem_words > 1) ? $clog2(mem_words) : 1;
  localparam int count_bits = (wait_cycles > 0) ? $clog2(wait_cycles + 1) : 1;
  localparam int lanes = $bits(strb_t);

  data_t mem [mem_words] = '{default: '0};

  logic [count_bits-1:0] wait_count;
  logic [index_bits-1:0] word_index;
  logic                  command;
  logic                  accept;

  assign command = m_avl_read || m_avl_write;
  // stall each command for wait_cycles, then take it.
  assign m_avl_waitrequest = command && (wait_count != count_bits'(wait_cycles));
  assign accept = command && !m_avl_waitrequest;
  assign word_index = index_bits'((m_avl_address >> word_offset_bits) % addr_t'(mem_words));

  always_ff @(posedge clock) begin
    if (!reset) begin
      wait_count <= '0;
      m_avl_readdatavalid <= 1'b0;
    end else begin
      if (accept) begin
        wait_count <= '0;
      end else if (command) begin
        wait_count <= wait_count + 1'b1;
      end
      m_avl_readdatavalid <= accept && m_avl_read;
    end
  end

  always_ff @(posedge clock) begin
    if (accept && m_avl_write) begin
      for (int b = 0; b < lanes; b++) begin
        if (m_avl_byteenable[b]) begin
          mem[word_index][8*b +: 8] <= m_avl_writedata[8*b +: 8];
        end
      end
    end
    if (accept && m_avl_read) begin
      m_avl_readdata <= mem[word_index]; // whole word.
    end
  end

endmodule

//--- design/mem_top.sv
`timescale 1ns/1ns

module mem_top import mem_pkg::*; #(
  parameter int fifo_depth = 4,
  parameter int wait_cycles = 2,
  parameter int mem_words = 256
) (
  input  logic  clock,
  input  logic  reset,
  input  logic  req_valid,
  input  addr_t req_addr,
  input  data_t req_wdata,
  input  strb_t req_wstrb,
  output logic  req_ready,
  output logic  rsp_valid,
  output data_t rsp_rdata
);

  logic   push;
  logic   full;
  logic   head_valid;
  addr_t  head_addr;
  data_t  head_wdata;
  strb_t  head_wstrb;
  logic   head_pop;

  addr_t  m_avl_address;
  strb_t  m_avl_byteenable;
  logic   m_avl_read;
  logic   m_avl_write;
  data_t  m_avl_writedata;
  burst_t m_avl_burstcount;
  logic   m_avl_lock;
  data_t  m_avl_readdata;
  logic   m_avl_waitrequest;
  logic   m_avl_readdatavalid;

  assign req_ready = !full;
  assign push = req_valid && req_ready; // request transfer.

  req_fifo #(
    .fifo_depth(fifo_depth)
  ) u_fifo (
    .clock(clock),
    .reset(reset),
    .push(push),
    .push_addr(req_addr),
    .push_wdata(req_wdata),
    .push_wstrb(req_wstrb),
    .head_pop(head_pop),
    .full(full),
    .head_valid(head_valid),
    .head_addr(head_addr),
    .head_wdata(head_wdata),
    .head_wstrb(head_wstrb)
  );

  avl_master u_master (
    .clock(clock),
    .reset(reset),
    .head_valid(head_valid),
    .head_addr(head_addr),
    .head_wdata(head_wdata),
    .head_wstrb(head_wstrb),
    .head_pop(head_pop),
    .rsp_valid(rsp_valid),
    .rsp_rdata(rsp_rdata),
    .m_avl_address(m_avl_address),
    .m_avl_byteenable(m_avl_byteenable),
    .m_avl_read(m_avl_read),
    .m_avl_write(m_avl_write),
    .m_avl_writedata(m_avl_writedata),
    .m_avl_burstcount(m_avl_burstcount),
    .m_avl_lock(m_avl_lock),
    .m_avl_readdata(m_avl_readdata),
    .m_avl_waitrequest(m_avl_waitrequest),
    .m_avl_readdatavalid(m_avl_readdatavalid)
  );

  avl_ram #(
    .wait_cycles(wait_cycles),
    .mem_words(mem_words)
  ) u_ram (
    .clock(clock),
    .reset(reset),
    .m_avl_address(m_avl_address),
    .m_avl_byteenable(m_avl_byteenable),
    .m_avl_read(m_avl_read),
    .m_avl_write(m_avl_write),
    .m_avl_writedata(m_avl_writedata),
    .m_avl_burstcount(m_avl_burstcount),
    .m_avl_lock(m_avl_lock),
    .m_avl_readdata(m_avl_readdata),
    .m_avl_waitrequest(m_avl_waitrequest),
    .m_avl_readdatavalid(m_avl_readdatavalid)
  );

endmodule

//--- tb/mem_assert.sv
`timescale 1ns/1ns

module mem_assert import mem_pkg::*; (
  input logic   clock,
  input logic   reset,
  input logic   req_ready,
  input logic   rsp_valid,
  input data_t  rsp_rdata,
  input addr_t  m_avl_address,
  input strb_t  m_avl_byteenable,
  input logic   m_avl_read,
  input logic   m_avl_write,
  input data_t  m_avl_writedata,
  input burst_t m_avl_burstcount,
  input data_t  m_avl_readdata,
  input logic   m_avl_waitrequest,
  input logic   m_avl_readdatavalid
);

  int failures = 0; // watched by the testbench.

  no_read_write_overlap: assert property (@(posedge clock) disable iff (!reset)
    !(m_avl_read && m_avl_write))
    else begin failures++; $error("read and write high together"); end

  // stalled command must not move.
  command_stable: assert property (@(posedge clock) disable iff (!reset)
    (m_avl_read || m_avl_write) && m_avl_waitrequest |=>
      $stable({m_avl_address, m_avl_byteenable, m_avl_writedata, m_avl_read, m_avl_write}))
    else begin failures++; $error("command changed under waitrequest"); end

  address_aligned: assert property (@(posedge clock) disable iff (!reset)
    (m_avl_read || m_avl_write) |-> m_avl_address[word_offset_bits-1:0] == '0)
    else begin failures++; $error("unaligned address %h", m_avl_address); end

  read_all_lanes: assert property (@(posedge clock) disable iff (!reset)
    m_avl_read |-> m_avl_byteenable == '1)
    else begin failures++; $error("read without all byte enables"); end

  single_beat: assert property (@(posedge clock) disable iff (!reset)
    (m_avl_read || m_avl_write) |-> m_avl_burstcount == burst_t'(1))
    else begin failures++; $error("burst count is not one"); end

  store_response: assert property (@(posedge clock) disable iff (!reset)
    m_avl_write && !m_avl_waitrequest |=> rsp_valid && rsp_rdata == '0)
    else begin failures++; $error("store response missing or data not zero"); end

  load_response: assert property (@(posedge clock) disable iff (!reset)
    m_avl_readdatavalid |=> rsp_valid && rsp_rdata == $past(m_avl_readdata))
    else begin failures++; $error("load response missing or wrong data"); end

  response_pulse: assert property (@(posedge clock) disable iff (!reset)
    rsp_valid |=> !rsp_valid)
    else begin failures++; $error("rsp_valid longer than one cycle"); end

  reset_state: assert property (@(posedge clock)
    !reset |=> !rsp_valid && !m_avl_read && !m_avl_write && !m_avl_readdatavalid && req_ready)
    else begin failures++; $error("outputs not idle after reset"); end

endmodule

bind mem_top mem_assert u_assert (
  .clock(clock),
  .reset(reset),
  .req_ready(req_ready),
  .rsp_valid(rsp_valid),
  .rsp_rdata(rsp_rdata),
  .m_avl_address(m_avl_address),
  .m_avl_byteenable(m_avl_byteenable),
  .m_avl_read(m_avl_read),
  .m_avl_write(m_avl_write),
  .m_avl_writedata(m_avl_writedata),
  .m_avl_burstcount(m_avl_burstcount),
  .m_avl_readdata(m_avl_readdata),
  .m_avl_waitrequest(m_avl_waitrequest),
  .m_avl_readdatavalid(m_avl_readdatavalid)
);

//--- tb/mem_tb.sv
`timescale 1ns/1ns

module mem_tb import mem_pkg::*; ();

  localparam int clock_period = 20;
  localparam int seed_start = 62;
  localparam int num_directed = 17;
  localparam int num_random = 200;
  localparam int cycles_per_request = 40;
  localparam int timeout_ns = (num_directed + num_random) * cycles_per_request * clock_period;
  localparam int drain_cycles = 4 * cycles_per_request; // a full queue of requests.
  localparam int ram_words = 256;

  logic  clock;
  logic  reset;
  logic  req_valid;
  addr_t req_addr;
  data_t req_wdata;
  strb_t req_wstrb;
  logic  req_ready;
  logic  rsp_valid;
  data_t rsp_rdata;

  int    seed = seed_start;
  int    transfers = 0;
  int    responses = 0;
  int    stall_cycles = 0;
  logic  will_transfer;
  data_t ref_mem [ram_words] = '{default: '0};
  data_t exp_q [$];

  mem_top #(
    .fifo_depth(4),
    .wait_cycles(2),
    .mem_words(ram_words)
  ) u_dut (
    .clock(clock),
    .reset(reset),
    .req_valid(req_valid),
    .req_addr(req_addr),
    .req_wdata(req_wdata),
    .req_wstrb(req_wstrb),
    .req_ready(req_ready),
    .rsp_valid(rsp_valid),
    .rsp_rdata(rsp_rdata)
  );

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  function automatic int word_of(input addr_t addr);
    return int'((addr >> word_offset_bits) % ram_words);
  endfunction

  // strobed lanes take the new byte, the rest keep the old one.
  function automatic data_t merge_lanes(input data_t old_word, input data_t new_word,
                                        input strb_t lanes);
    data_t merged;
    merged = old_word;
    for (int b = 0; b < 8; b++) begin
      if (lanes[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

  // called on a falling edge, returns on the falling edge after the transfer.
  task automatic send_request(input addr_t addr, input data_t wdata, input strb_t wstrb);
    req_valid = 1'b1;
    req_addr = addr;
    req_wdata = wdata;
    req_wstrb = wstrb;
    will_transfer = req_ready;
    while (!will_transfer) begin
      stall_cycles++; // queue full.
      @(negedge clock);
      will_transfer = req_ready;
    end
    @(negedge clock);
    req_valid = 1'b0;
    will_transfer = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    req_valid = 1'b0;
    will_transfer = 1'b0;
    repeat (n) @(negedge clock);
  endtask

  task automatic send_random(input bit back_to_back);
    int    pick;
    addr_t addr;
    data_t wdata;
    strb_t wstrb;
    addr = addr_t'($random(seed)) & addr_t'(32'h3f); // eight words only.
    wdata[63:32] = $random(seed);
    wdata[31:0] = $random(seed);
    pick = $random(seed);
    if (pick[1:0] == 2'b00) begin
      wstrb = '0;
    end else begin
      wstrb = strb_t'($random(seed));
    end
    send_request(addr, wdata, wstrb);
    if (!back_to_back) begin
      pick = $random(seed);
      idle_cycles(pick & 3);
    end
  endtask

  // model updates on the edge where the request transfers.
  always @(posedge clock) begin
    if (will_transfer) begin
      transfers++;
      if (req_wstrb == '0) begin
        exp_q.push_back(ref_mem[word_of(req_addr)]);
      end else begin
        ref_mem[word_of(req_addr)] = merge_lanes(ref_mem[word_of(req_addr)], req_wdata,
                                                 req_wstrb);
        exp_q.push_back('0);
      end
    end
  end

  always @(negedge clock) begin
    if (reset && rsp_valid) begin
      if (exp_q.size() == 0) begin
        $display("a response arrived with no request outstanding at %0t", $time);
        $display("test failed");
        $fatal(1, "unexpected response");
      end else if (rsp_rdata !== exp_q[0]) begin
        $display("FAILED at %0t: rsp_rdata = %h, expected %h", $time, rsp_rdata, exp_q[0]);
        $display("test failed");
        $fatal(1, "response data mismatch");
      end else begin
        void'(exp_q.pop_front());
        responses++;
      end
    end
  end

  always @(negedge clock) begin
    if (u_dut.u_assert.failures != 0) begin
      $display("an assertion on the Avalon side or the responses failed at %0t", $time);
      $display("test failed");
      $fatal(1, "assertion failure");
    end
  end

  initial begin
    #(timeout_ns);
    $display("watchdog expired, the requests did not all complete in time");
    $display("test failed");
    $fatal(1, "simulation hung");
  end

  initial begin
    int n;
    reset = 1'b0;
    req_valid = 1'b0;
    req_addr = '0;
    req_wdata = '0;
    req_wstrb = '0;
    will_transfer = 1'b0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
    @(negedge clock);

    send_request(32'h10, 64'h1122_3344_5566_7788, 8'hff);
    send_request(32'h10, '0, 8'h00);
    send_request(32'h13, 64'haaaa_aaaa_aaaa_aaaa, 8'h0f); // low bits ignored.
    send_request(32'h17, '0, 8'h00);
    send_request(32'h20, 64'hdead_beef_cafe_f00d, 8'h81);
    send_request(32'h21, '0, 8'h00);
    send_request(32'h100, '0, 8'h00); // never written.
    for (n = 0; n < 8; n++) begin
      send_request(32'h40 | addr_t'(n), {8{8'(n + 1)}}, strb_t'(1 << n));
    end
    send_request(32'h40, '0, 8'h00);
    send_request(32'h10, '0, 8'h00);

    // alternate blocks of 25 back to back and with gaps.
    for (n = 0; n < num_random; n++) begin
      send_random(((n / 25) % 2) == 0);
    end

    idle_cycles(0);
    n = 0;
    while (exp_q.size() != 0 && n < drain_cycles) begin
      @(negedge clock);
      n++;
    end
    repeat (5) @(negedge clock);

    if (responses != transfers) begin
      $display("FAILED at %0t: responses = %0d, expected %0d", $time, responses, transfers);
      $display("test failed");
      $fatal(1, "response count mismatch");
    end else if (stall_cycles == 0) begin
      $display("the request queue never filled, req_ready stayed high");
      $display("test failed");
      $fatal(1, "back-pressure not reached");
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

//--- sim.f
design/mem_pkg.sv
design/req_fifo.sv
design/avl_master.sv
design/avl_ram.sv
design/mem_top.sv
tb/mem_assert.sv
tb/mem_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= mem_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the simulation printed the pass line.
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
